// ==== logic/fpconv_pkg.sv ====
package fpconv_pkg;

  // stream word and buffering
  localparam int DATA_W      = 32;  // one data word
  localparam int IN_DEPTH    = 4;   // input buffer slots, also initial sender credits
  localparam int OUT_CREDITS = 4;   // credits held for the downstream receiver

  // narrowing defaults
  localparam bit FTZ_DEFAULT = 1'b1;  // binary16 denormal results become signed zero

  // binary32 layout
  localparam int EXP32_W  = 8;
  localparam int FRAC32_W = 23;
  localparam int BIAS32   = 127;

  // binary16 layout
  localparam int EXP16_W  = 5;
  localparam int FRAC16_W = 10;
  localparam int BIAS16   = 15;

  // per-word mode bit
  localparam bit MODE_NARROW = 1'b0;  // binary32 in, binary16 out in low half
  localparam bit MODE_WIDEN  = 1'b1;  // binary16 in low half, binary32 out

  // the 32-bit word seen two ways
  // f32 is a single binary32 value
  // half[1] is the upper binary16 value, half[0] the lower one
  typedef union packed {
    struct packed {
      logic                sign;
      logic [EXP32_W-1:0]  exp;   // biased by BIAS32
      logic [FRAC32_W-1:0] frac;  // hidden bit not stored
    } f32;
    struct packed {
      logic                sign;
      logic [EXP16_W-1:0]  exp;   // biased by BIAS16
      logic [FRAC16_W-1:0] frac;
    } [1:0] half;
  } fp_word_u;

  // both views have to cover exactly one word
  // sign + 8 + 23 = 32
  // 2 * (sign + 5 + 10) = 32
  // changing a field width above breaks the union, so keep them in step

  // notes on the special encodings both converters share
  // all-ones exponent with zero fraction is infinity
  // all-ones exponent with nonzero fraction is NaN, always output quiet
  // zero exponent is zero or denormal
  // quiet NaN output sets only the top fraction bit

endpackage

// ==== logic/fp32_to_fp16.sv ====
module fp32_to_fp16 #(
  parameter bit FTZ = fpconv_pkg::FTZ_DEFAULT  // flush denormal results to signed zero
) (
  input  logic [31:0] fp32_i,  // binary32
  output logic [15:0] fp16_o   // binary16
);
  import fpconv_pkg::*;

  logic                        sign;
  logic [EXP32_W-1:0]          exp32;
  logic [FRAC32_W-1:0]         frac32;
  logic signed [EXP32_W+1:0]   e16;       // rebiased exponent, can go negative
  logic signed [EXP32_W+1:0]   sh_raw;    // denormal shift before clipping
  logic [4:0]                  sh;
  logic [FRAC32_W+26:0]        ext;       // hidden bit, fraction, 26 spill bits
  logic [FRAC32_W+26:0]        shifted;
  logic [FRAC16_W-1:0]         mant;
  logic                        guard;
  logic                        rnd;
  logic                        sticky;
  logic                        round_up;
  logic [EXP16_W-1:0]          exp_base;
  logic [EXP16_W+FRAC16_W-1:0] mag_r;     // exponent and fraction after rounding
  logic                        is_special;
  logic                        is_zero;
  logic                        ovf;
  logic                        unf;

  assign {sign, exp32, frac32} = fp32_i;

  assign e16 = $signed({2'b00, exp32}) - (EXP32_W+2)'(BIAS32 - BIAS16);

  assign is_special = &exp32;           // inf or nan
  assign is_zero    = ~|exp32;          // zero, binary32 denormals are far below range
  assign ovf        = e16 >= (1 << EXP16_W) - 1;
  assign unf        = e16 <= 0;         // lands in binary16 denormal range

  // how far the hidden bit moves right for a denormal result
  assign sh_raw = (EXP32_W+2)'(1) - e16;

  always_comb begin
    if (!unf) begin
      sh = '0;                          // normal result, no shift
    end else if (sh_raw > 26) begin
      sh = 5'd26;                       // everything already below guard
    end else begin
      sh = sh_raw[4:0];
    end
  end

  assign ext     = {1'b1, frac32, 26'b0};
  assign shifted = ext >> sh;

  // top 10 fraction bits, then guard, round and sticky below them
  assign mant   = shifted[FRAC32_W+25 -: FRAC16_W];
  assign guard  = shifted[FRAC32_W+25-FRAC16_W];
  assign rnd    = shifted[FRAC32_W+24-FRAC16_W];
  assign sticky = |shifted[FRAC32_W+23-FRAC16_W:0];

  // nearest-even, tie goes to even lsb
  assign round_up = guard & (rnd | sticky | mant[0]);

  // carry out of the fraction ripples into the exponent for free
  assign exp_base = unf ? '0 : e16[EXP16_W-1:0];
  assign mag_r    = {exp_base, mant} + (EXP16_W+FRAC16_W)'(round_up);  // 30 + carry gives inf

  always_comb begin
    if (is_special) begin
      if (frac32 != '0) begin
        fp16_o = {sign, {EXP16_W{1'b1}}, 1'b1, {(FRAC16_W-1){1'b0}}};  // quiet nan
      end else begin
        fp16_o = {sign, {EXP16_W{1'b1}}, {FRAC16_W{1'b0}}};            // inf
      end
    end else if (ovf) begin
      fp16_o = {sign, {EXP16_W{1'b1}}, {FRAC16_W{1'b0}}};   // too big, inf
    end else if (is_zero || (unf && FTZ)) begin
      fp16_o = {sign, {(EXP16_W+FRAC16_W){1'b0}}};          // signed zero
    end else begin
      fp16_o = {sign, mag_r};
    end
  end

endmodule

// ==== logic/fp16_to_fp32.sv ====
module fp16_to_fp32 (
  input  logic [15:0] fp16_i,  // binary16
  output logic [31:0] fp32_o   // binary32, always exact
);
  import fpconv_pkg::*;

  logic                sign;
  logic [EXP16_W-1:0]  exp16;
  logic [FRAC16_W-1:0] frac16;
  logic [3:0]          lz;         // leading zeros of a denormal fraction
  logic [FRAC16_W-1:0] norm_frac;  // fraction with leading one shifted out
  logic [EXP32_W-1:0]  exp_norm;
  logic [EXP32_W-1:0]  exp_sub;

  assign {sign, exp16, frac16} = fp16_i;

  // highest set bit wins, loop runs upward
  always_comb begin
    lz = '0;
    for (int i = 0; i < FRAC16_W; i++) begin
      if (frac16[i]) begin
        lz = 4'(FRAC16_W - 1 - i);
      end
    end
  end

  assign norm_frac = frac16 << (lz + 4'd1);  // drop the leading one, it becomes hidden

  assign exp_norm = EXP32_W'(exp16) + EXP32_W'(BIAS32 - BIAS16);
  assign exp_sub  = EXP32_W'(BIAS32 - BIAS16) - EXP32_W'(lz);  // 0x0001 lands at 103

  always_comb begin
    if (&exp16) begin
      if (frac16 != '0) begin
        fp32_o = {sign, {EXP32_W{1'b1}}, 1'b1, {(FRAC32_W-1){1'b0}}};  // quiet nan
      end else begin
        fp32_o = {sign, {EXP32_W{1'b1}}, {FRAC32_W{1'b0}}};            // inf
      end
    end else if (exp16 == '0) begin
      if (frac16 == '0) begin
        fp32_o = {sign, {(EXP32_W+FRAC32_W){1'b0}}};  // signed zero
      end else begin
        fp32_o = {sign, exp_sub, norm_frac, {(FRAC32_W-FRAC16_W){1'b0}}};
      end
    end else begin
      fp32_o = {sign, exp_norm, frac16, {(FRAC32_W-FRAC16_W){1'b0}}};  // plain rebias
    end
  end

endmodule

// ==== logic/fpconv_in_fifo.sv ====
module fpconv_in_fifo (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          wr_valid_i,  // sender spent a credit
  input  logic                          wr_mode_i,
  input  logic [fpconv_pkg::DATA_W-1:0] wr_data_i,
  input  logic                          pop_i,
  output logic                          head_valid_o,
  output logic                          head_mode_o,
  output logic [fpconv_pkg::DATA_W-1:0] head_data_o,
  output logic                          credit_o     // one slot back to the sender
);
  import fpconv_pkg::*;

  logic                          mode_mem [IN_DEPTH];
  logic [DATA_W-1:0]             data_mem [IN_DEPTH];
  logic [$clog2(IN_DEPTH)-1:0]   wr_ptr_q;
  logic [$clog2(IN_DEPTH)-1:0]   rd_ptr_q;
  logic [$clog2(IN_DEPTH+1)-1:0] count_q;   // occupancy 0..IN_DEPTH
  logic                          pop;

  assign head_valid_o = count_q != '0;
  assign head_mode_o  = mode_mem[rd_ptr_q];
  assign head_data_o  = data_mem[rd_ptr_q];

  assign pop      = pop_i & head_valid_o;  // never pop an empty buffer
  assign credit_o = pop;                   // same cycle as the pop

  // storage, sender credits keep it from overflowing
  always_ff @(posedge clk_i) begin
    if (wr_valid_i) begin
      mode_mem[wr_ptr_q] <= wr_mode_i;
      data_mem[wr_ptr_q] <= wr_data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (wr_valid_i) begin
        wr_ptr_q <= (wr_ptr_q == IN_DEPTH - 1) ? '0 : wr_ptr_q + 1'b1;  // wrap
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == IN_DEPTH - 1) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({wr_valid_i, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;         // idle or push and pop together
      endcase
    end
  end

endmodule

// ==== logic/fpconv_engine.sv ====
module fpconv_engine (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          head_valid_i,
  input  logic                          head_mode_i,   // MODE_NARROW or MODE_WIDEN
  input  logic [fpconv_pkg::DATA_W-1:0] head_data_i,
  input  logic                          out_credit_i,  // receiver freed one slot
  input  logic [15:0]                   narrow_res_i,
  input  logic [31:0]                   wide_res_i,
  output logic                          pop_o,
  output logic [31:0]                   narrow_op_o,
  output logic [15:0]                   wide_op_o,
  output logic                          out_valid_o,
  output logic [fpconv_pkg::DATA_W-1:0] out_data_o
);
  import fpconv_pkg::*;

  fp_word_u                         head_w;      // incoming word, both views
  fp_word_u                         res_w;       // result word being built
  logic [$clog2(OUT_CREDITS+1)-1:0] out_cred_q;  // downstream slots still free
  logic                             has_credit;

  assign head_w = head_data_i;

  // binary32 view to the narrower, low binary16 half to the widener
  assign narrow_op_o = head_w.f32;
  assign wide_op_o   = head_w.half[0];

  // a credit arriving this cycle can be spent right away
  assign has_credit = (out_cred_q != '0) | out_credit_i;
  assign pop_o      = head_valid_i & has_credit;

  always_comb begin
    unique case (head_mode_i)
      MODE_NARROW: begin
        res_w.half[1] = '0;           // high half stays clear
        res_w.half[0] = narrow_res_i;
      end
      MODE_WIDEN: begin
        res_w.f32 = wide_res_i;
      end
    endcase
  end

  // credit count, spent on pop and refilled by out_credit_i
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      out_cred_q <= ($clog2(OUT_CREDITS+1))'(OUT_CREDITS);
    end else begin
      case ({pop_o, out_credit_i})
        2'b10:   out_cred_q <= out_cred_q - 1'b1;
        2'b01:   out_cred_q <= out_cred_q + 1'b1;
        default: out_cred_q <= out_cred_q;         // none or spent as it came
      endcase
    end
  end

  // output stage, one cycle after the pop
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      out_valid_o <= 1'b0;
    end else begin
      out_valid_o <= pop_o;
    end
  end

  always_ff @(posedge clk_i) begin
    if (pop_o) begin
      out_data_o <= res_w;
    end
  end

endmodule

// ==== logic/fpconv_top.sv ====
module fpconv_top (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          in_valid_i,
  input  logic                          in_mode_i,
  input  logic [fpconv_pkg::DATA_W-1:0] in_data_i,
  output logic                          in_credit_o,
  output logic                          out_valid_o,
  output logic [fpconv_pkg::DATA_W-1:0] out_data_o,
  input  logic                          out_credit_i
);
  import fpconv_pkg::*;

  logic              fifo_valid;
  logic              fifo_mode;
  logic [DATA_W-1:0] fifo_data;
  logic              fifo_pop;
  logic [31:0]       narrow_op;   // binary32 operand
  logic [15:0]       narrow_res;
  logic [15:0]       wide_op;     // binary16 operand
  logic [31:0]       wide_res;

  fpconv_in_fifo u_in_fifo (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .wr_valid_i   (in_valid_i),
    .wr_mode_i    (in_mode_i),
    .wr_data_i    (in_data_i),
    .pop_i        (fifo_pop),
    .head_valid_o (fifo_valid),
    .head_mode_o  (fifo_mode),
    .head_data_o  (fifo_data),
    .credit_o     (in_credit_o)
  );

  fpconv_engine u_engine (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .head_valid_i (fifo_valid),
    .head_mode_i  (fifo_mode),
    .head_data_i  (fifo_data),
    .out_credit_i (out_credit_i),
    .narrow_res_i (narrow_res),
    .wide_res_i   (wide_res),
    .pop_o        (fifo_pop),
    .narrow_op_o  (narrow_op),
    .wide_op_o    (wide_op),
    .out_valid_o  (out_valid_o),
    .out_data_o   (out_data_o)
  );

  fp32_to_fp16 u_narrow (
    .fp32_i (narrow_op),
    .fp16_o (narrow_res)
  );

  fp16_to_fp32 u_widen (
    .fp16_i (wide_op),
    .fp32_o (wide_res)
  );

endmodule

// ==== test/fpconv_asserts.sv ====
module fpconv_asserts (
  input logic                                          clk_i,
  input logic                                          rst_n_i,
  input logic                                          in_valid_i,   // buffer write
  input logic                                          in_credit_i,
  input logic                                          out_valid_i,
  input logic [$clog2(fpconv_pkg::OUT_CREDITS+1)-1:0] out_cred_i,   // engine credit count
  input logic [$clog2(fpconv_pkg::IN_DEPTH+1)-1:0]    fifo_count_i  // buffer occupancy
);
  timeunit 1ns;
  timeprecision 1ps;
  import fpconv_pkg::*;

  // first reset edge clears the regs, from the second one on both stay low
  property quiet_in_reset;
    @(posedge clk_i) (!rst_n_i ##1 !rst_n_i) |-> (!out_valid_i && !in_credit_i);
  endproperty

  property credit_in_range;
    @(posedge clk_i) disable iff (!rst_n_i)
      out_cred_i <= OUT_CREDITS;  // unsigned, so never below zero
  endproperty

  // sender credits keep a full buffer from being written
  property no_write_when_full;
    @(posedge clk_i) disable iff (!rst_n_i)
      in_valid_i |-> (fifo_count_i < IN_DEPTH);
  endproperty

  a_quiet_in_reset: assert property (quiet_in_reset)
    else $error("out_valid_o or in_credit_o high during reset");

  a_credit_in_range: assert property (credit_in_range)
    else $error("engine output credit count above OUT_CREDITS");

  a_no_write_when_full: assert property (no_write_when_full)
    else $error("input buffer written while full");

endmodule

// ==== test/fpconv_tb.sv ====
module fpconv_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import fpconv_pkg::*;

  localparam int          HOLD_WORDS  = IN_DEPTH + OUT_CREDITS;  // fills output credits, then buffer
  localparam int          HOLD_WINDOW = 30;    // cycles watched with credits held back
  localparam int          CREDIT_WAIT = 200;   // longest wait for one input credit
  localparam int          DRAIN_WAIT  = 2000;  // longest wait for the unit to drain
  localparam int unsigned SEED        = 32'he5976bc5;

  logic        clk_i;
  logic        rst_n_i;
  logic        in_valid_i;
  logic        in_mode_i;
  logic [31:0] in_data_i;
  logic        in_credit_o;
  logic        out_valid_o;
  logic [31:0] out_data_o;
  logic        out_credit_i;

  // stimulus table, one row per word
  bit          tbl_mode [$];
  logic [31:0] tbl_in   [$];
  logic [31:0] tbl_exp  [$];

  int words_sent    = 0;  // sender side only
  int credit_pulses = 0;  // in_credit_o pulses, updated with nba
  int outputs_seen  = 0;  // out_valid_o words, updated with nba
  int owed_credits  = 0;  // slots the receiver still holds
  int data_errors   = 0;
  int credit_errors = 0;
  int timeouts      = 0;
  bit hold_credits;       // receiver keeps every credit while set
  bit run_aborted   = 1'b0;

  always #2 clk_i = ~clk_i;  // 4 ns period

  fpconv_top DUT (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .in_valid_i   (in_valid_i),
    .in_mode_i    (in_mode_i),
    .in_data_i    (in_data_i),
    .in_credit_o  (in_credit_o),
    .out_valid_o  (out_valid_o),
    .out_data_o   (out_data_o),
    .out_credit_i (out_credit_i)
  );

  bind fpconv_top fpconv_asserts u_asserts (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .in_valid_i   (in_valid_i),
    .in_credit_i  (in_credit_o),
    .out_valid_i  (out_valid_o),
    .out_cred_i   (u_engine.out_cred_q),
    .fifo_count_i (u_in_fifo.count_q)
  );

  task automatic add_vector(input bit mode, input logic [31:0] word, input logic [31:0] exp_word);
    tbl_mode.push_back(mode);
    tbl_in.push_back(word);
    tbl_exp.push_back(exp_word);
  endtask

  // expected words from the ieee rules, modes mixed on purpose
  task automatic build_table();
    add_vector(MODE_NARROW, 32'h3F80_0000, 32'h0000_3C00);  // 1.0
    add_vector(MODE_WIDEN,  32'h0000_3C00, 32'h3F80_0000);
    add_vector(MODE_NARROW, 32'hC020_0000, 32'h0000_C100);  // -2.5
    add_vector(MODE_WIDEN,  32'hDEAD_C100, 32'hC020_0000);  // high half ignored
    add_vector(MODE_NARROW, 32'h3F80_1000, 32'h0000_3C00);  // tie, stays even
    add_vector(MODE_NARROW, 32'h3F80_3000, 32'h0000_3C02);  // tie, odd goes up
    add_vector(MODE_WIDEN,  32'h0000_0001, 32'h3380_0000);  // smallest denormal
    add_vector(MODE_NARROW, 32'h3F80_1001, 32'h0000_3C01);  // just above tie
    add_vector(MODE_NARROW, 32'h3FFF_F000, 32'h0000_4000);  // carry into exponent
    add_vector(MODE_WIDEN,  32'h0000_03FF, 32'h387F_C000);  // largest denormal
    add_vector(MODE_NARROW, 32'h3F80_0FFF, 32'h0000_3C00);  // just below tie
    add_vector(MODE_NARROW, 32'h0000_0000, 32'h0000_0000);  // +0
    add_vector(MODE_NARROW, 32'h8000_0000, 32'h0000_8000);  // -0
    add_vector(MODE_WIDEN,  32'h0000_7C00, 32'h7F80_0000);  // +inf
    add_vector(MODE_NARROW, 32'h7F80_0000, 32'h0000_7C00);
    add_vector(MODE_NARROW, 32'hFF80_0000, 32'h0000_FC00);
    add_vector(MODE_WIDEN,  32'h0000_FC00, 32'hFF80_0000);  // -inf
    add_vector(MODE_NARROW, 32'h7FC0_0000, 32'h0000_7E00);  // quiet nan
    add_vector(MODE_NARROW, 32'hFF80_0001, 32'h0000_FE00);  // signalling nan, sign kept
    add_vector(MODE_WIDEN,  32'h0000_7E01, 32'h7FC0_0000);
    add_vector(MODE_WIDEN,  32'h0000_FD00, 32'hFFC0_0000);
    add_vector(MODE_NARROW, 32'h477F_E000, 32'h0000_7BFF);  // 65504, max half
    add_vector(MODE_NARROW, 32'h4780_0000, 32'h0000_7C00);  // 65536 overflows
    add_vector(MODE_NARROW, 32'h477F_F000, 32'h0000_7C00);  // rounds up into inf
    add_vector(MODE_NARROW, 32'hC780_0000, 32'h0000_FC00);
    add_vector(MODE_WIDEN,  32'h0000_7BFF, 32'h477F_E000);
    add_vector(MODE_NARROW, 32'h3880_0000, 32'h0000_0400);  // smallest normal half
    add_vector(MODE_NARROW, 32'h3800_0000, 32'h0000_0000);  // flushed to +0
    add_vector(MODE_NARROW, 32'hB380_0000, 32'h0000_8000);  // flushed to -0
    add_vector(MODE_WIDEN,  32'h0000_0000, 32'h0000_0000);
    add_vector(MODE_WIDEN,  32'h0000_8000, 32'h8000_0000);
    add_vector(MODE_WIDEN,  32'h0000_8200, 32'hB800_0000);  // -2^-15 denormal
    add_vector(MODE_WIDEN,  32'h0000_0400, 32'h3880_0000);
    add_vector(MODE_NARROW, 32'h7F7F_FFFF, 32'h0000_7C00);  // max float
    add_vector(MODE_NARROW, 32'h3E2A_AAAB, 32'h0000_3155);  // about 1/6
  endtask

  function automatic int sender_credits();
    return IN_DEPTH - words_sent + credit_pulses;
  endfunction

  // walks table rows first..last-1, random idle gaps, never spends a missing credit
  task automatic send_range(input int first, input int last);
    int gap;
    int waited;
    for (int idx = first; idx < last && !run_aborted; idx++) begin
      gap = $urandom_range(0, 2);
      for (int k = 0; k < gap; k++) begin
        @(posedge clk_i);
        in_valid_i <= 1'b0;
      end
      waited = 0;
      @(posedge clk_i);
      while (sender_credits() == 0 && waited < CREDIT_WAIT) begin
        in_valid_i <= 1'b0;  // out of credits, stall
        @(posedge clk_i);
        waited++;
      end
      if (sender_credits() == 0) begin
        $display("timeout: no input credit came back within %0d cycles before entry %0d",
                 CREDIT_WAIT, idx);
        timeouts++;
        run_aborted = 1'b1;
      end else begin
        in_valid_i <= 1'b1;
        in_mode_i  <= tbl_mode[idx];
        in_data_i  <= tbl_in[idx];
        words_sent++;
      end
    end
    @(posedge clk_i);
    in_valid_i <= 1'b0;
  endtask

  task automatic wait_for_outputs(input int target, input int limit, input string what);
    int cycles;
    cycles = 0;
    while (outputs_seen < target && cycles < limit) begin
      @(posedge clk_i);
      cycles++;
    end
    if (outputs_seen < target) begin
      $display("timeout: %s never arrived, %0d of %0d outputs after %0d cycles",
               what, outputs_seen, target, limit);
      timeouts++;
      run_aborted = 1'b1;
    end
  endtask

  task automatic check_output(input int idx);
    assert (idx < tbl_exp.size()) else begin
      $display("error %0t: extra output %h after the last table entry", $time, out_data_o);
      data_errors++;
    end
    if (idx < tbl_exp.size()) begin
      assert (out_data_o === tbl_exp[idx]) else begin
        $display("error %0t: entry %0d %s in %h got %h expected %h", $time, idx,
                 (tbl_mode[idx] == MODE_WIDEN) ? "widen" : "narrow",
                 tbl_in[idx], out_data_o, tbl_exp[idx]);
        data_errors++;
      end
    end
  endtask

  // receiver and monitor in one process, so counts and credits stay in step
  task automatic receive_and_check();
    forever begin
      @(posedge clk_i);
      if (!rst_n_i) begin
        out_credit_i <= 1'b0;
      end else begin
        if (in_credit_o) begin
          credit_pulses <= credit_pulses + 1;
        end
        if (out_valid_o) begin
          check_output(outputs_seen);  // old value, next row in order
          outputs_seen <= outputs_seen + 1;
          owed_credits++;
        end
        if (!hold_credits && owed_credits > 0 && $urandom_range(0, 2) == 0) begin
          out_credit_i <= 1'b1;  // slot freed after a random delay
          owed_credits--;
        end else begin
          out_credit_i <= 1'b0;
        end
      end
    end
  endtask

  initial begin
    clk_i        = 1'b0;
    rst_n_i      = 1'b0;
    in_valid_i   = 1'b0;
    in_mode_i    = 1'b0;
    in_data_i    = '0;
    out_credit_i = 1'b0;
    hold_credits = 1'b1;  // start with the receiver stalled
    void'($urandom(SEED));
    fork
      receive_and_check();
    join_none
    build_table();
    repeat (5) @(posedge clk_i);
    rst_n_i <= 1'b1;

    // receiver holds back, only OUT_CREDITS words may leave
    send_range(0, HOLD_WORDS);
    if (!run_aborted) begin
      wait_for_outputs(OUT_CREDITS, CREDIT_WAIT, "the first outputs under credit hold");
    end
    if (!run_aborted) begin
      repeat (HOLD_WINDOW) @(posedge clk_i);
      assert (outputs_seen <= OUT_CREDITS) else begin
        $display("error %0t: %0d outputs with credits held, limit %0d",
                 $time, outputs_seen, OUT_CREDITS);
        credit_errors++;
      end
      hold_credits <= 1'b0;  // traffic resumes
    end

    send_range(HOLD_WORDS, tbl_in.size());
    if (!run_aborted) begin
      wait_for_outputs(tbl_in.size(), DRAIN_WAIT, "the last table output");
    end
    if (!run_aborted) begin
      repeat (10) @(posedge clk_i);  // catch stray words
      assert (outputs_seen == tbl_in.size()) else begin
        $display("error %0t: %0d outputs for %0d table entries",
                 $time, outputs_seen, tbl_in.size());
        credit_errors++;
      end
      assert (credit_pulses == words_sent) else begin
        $display("error %0t: %0d input credits returned for %0d words sent",
                 $time, credit_pulses, words_sent);
        credit_errors++;
      end
    end

    $display("checks done: %0d data errors, %0d credit errors, %0d timeouts",
             data_errors, credit_errors, timeouts);
    if (data_errors + credit_errors + timeouts == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
logic/fpconv_pkg.sv
logic/fp32_to_fp16.sv
logic/fp16_to_fp32.sv
logic/fpconv_in_fifo.sv
logic/fpconv_engine.sv
logic/fpconv_top.sv
test/fpconv_asserts.sv
test/fpconv_tb.sv

// ==== Bender.yml ====
package:
  name: fpconv

sources:
  # design, package first
  - files:
      - logic/fpconv_pkg.sv
      - logic/fp32_to_fp16.sv
      - logic/fp16_to_fp32.sv
      - logic/fpconv_in_fifo.sv
      - logic/fpconv_engine.sv
      - logic/fpconv_top.sv

  # testbench and bound assertions
  - target: test
    files:
      - test/fpconv_asserts.sv
      - test/fpconv_tb.sv
